// File: hdl/lsq_defines.svh
// ======================================================================
// Load/store queue geometry
// Queue depth, index widths, address widths and page layout shared by
// every block of the load/store queue
// ======================================================================
`ifndef LSQ_DEFINES_SVH
`define LSQ_DEFINES_SVH

// Queue depth and index widths
`define LSQ_ENTRIES 8
`define LSQ_IDX_W 3
`define ROB_IDX_W 5
`define SEQ_W 8

// Address layout, 64-byte pages
`define VADR_W 16
`define PADR_W 20
`define PAGE_BITS 6
`define VPN_W 10
`define PPN_W 14

`define DATA_W 32
`endif

// File: hdl/lsq_pkg.sv
// ======================================================================
// Load/store queue types
// Memory operation kinds, access sizes and the command opcodes passed
// from the queue control to the entry array
// ======================================================================
package lsq_pkg;

	// Operation kind, set at enqueue time
	typedef enum logic {
		MK_LOAD  = 1'b0,
		MK_STORE = 1'b1
	} mem_kind_e;

	// Access size, the fourth code is not a legal size
	typedef enum logic [1:0] {
		MS_BYTE = 2'd0,
		MS_HALF = 2'd1,
		MS_WORD = 2'd2
	} mem_size_e;

	// Queue commands
	// Each command lane carries one of these next to its operands
	typedef enum logic [2:0] {
		CMD_NONE   = 3'd0,
		CMD_ENQ    = 3'd1,
		CMD_SETADR = 3'd2,
		CMD_ISSUE  = 3'd3,
		CMD_SETRES = 3'd4,
		CMD_INV    = 3'd5
	} lsq_cmd_e;

endpackage

// File: hdl/lsq_ctrl.sv
// ======================================================================
// Load/store queue control
// Allocates free entries, hands out sequence numbers and turns the
// incoming strobes into command lanes for the entry array
// ======================================================================
`timescale 1ns/1ps
`include "lsq_defines.svh"

module lsq_ctrl import lsq_pkg::*; (
	input  logic                   clk,
	input  logic                   rst,
	input  logic                   enq_valid,
	input  logic [`ROB_IDX_W-1:0]  enq_rob,
	input  mem_kind_e              enq_kind,
	input  mem_size_e              enq_size,
	input  logic                   xl_valid,
	input  logic [`ROB_IDX_W-1:0]  xl_rob,
	input  logic [`PADR_W-1:0]     xl_padr,
	input  logic                   iss_valid,
	input  logic [`LSQ_IDX_W-1:0]  iss_idx,
	input  logic                   mem_resp_valid,
	input  logic [`LSQ_IDX_W-1:0]  mem_resp_idx,
	input  logic [`DATA_W-1:0]     mem_resp_data,
	input  logic [`LSQ_ENTRIES-1:0] ent_valid,
	output lsq_cmd_e               cmd_enq,
	output logic [`LSQ_IDX_W-1:0]  enq_idx,
	output logic [`SEQ_W-1:0]      enq_seq,
	output lsq_cmd_e               cmd_set,
	output logic [`ROB_IDX_W-1:0]  set_rob,
	output logic [`PADR_W-1:0]     set_padr,
	output lsq_cmd_e               cmd_iss,
	output logic [`LSQ_IDX_W-1:0]  iss_idx_o,
	output lsq_cmd_e               cmd_res,
	output logic [`LSQ_IDX_W-1:0]  res_idx,
	output logic [`DATA_W-1:0]     res_data,
	output logic [`SEQ_W-1:0]      seq_now,
	output logic                   lsq_full,
	output logic [`LSQ_IDX_W:0]    lsq_count
);

	localparam int IW = `LSQ_IDX_W;

	logic [`SEQ_W-1:0] seq_q;
	logic [IW-1:0] free_idx;
	logic free_any;
	logic enq_ok;

	// ==================================================================
	// Allocation and occupancy
	// ==================================================================

	// Scan from the top so the lowest free entry wins
	always_comb begin
		free_idx = '0;
		free_any = 1'b0;
		lsq_count = '0;
		for (int i = `LSQ_ENTRIES - 1; i >= 0; i--) begin
			if (!ent_valid[i]) begin
				free_idx = IW'(i);
				free_any = 1'b1;
			end
		end
		for (int i = 0; i < `LSQ_ENTRIES; i++)
			lsq_count = lsq_count + {{IW{1'b0}}, ent_valid[i]};
	end

	assign lsq_full = !free_any;

	// An enqueue into a full queue is dropped
	assign enq_ok = enq_valid && free_any;

	// The sequence counter moves once per accepted enqueue
	always_ff @(posedge clk) begin
		if (rst)
			seq_q <= '0;
		else if (enq_ok)
			seq_q <= seq_q + 1'b1;
	end

	assign seq_now = seq_q;
	assign cmd_enq = enq_ok ? CMD_ENQ : CMD_NONE;
	assign enq_idx = free_idx;
	assign enq_seq = seq_q;

	// ==================================================================
	// Set-address lane
	// ==================================================================

	// A translation whose entry is not valid finds no match in the array
	assign cmd_set = xl_valid ? CMD_SETADR : CMD_NONE;
	assign set_rob = xl_rob;
	assign set_padr = xl_padr;

	// Issue and result lanes
	// A response to a freed entry is ignored
	assign cmd_iss = iss_valid ? CMD_ISSUE : CMD_NONE;
	assign iss_idx_o = iss_idx;
	assign cmd_res = (mem_resp_valid && ent_valid[mem_resp_idx]) ? CMD_SETRES : CMD_NONE;
	assign res_idx = mem_resp_idx;
	assign res_data = mem_resp_data;

endmodule

// File: hdl/lsq_entries.sv
// ======================================================================
// Load/store queue entry array
// Holds the per-entry state and applies the enqueue, set-address,
// issue, result and invalidate commands
// ======================================================================
`timescale 1ns/1ps
`include "lsq_defines.svh"

module lsq_entries import lsq_pkg::*; (
	input  logic                    clk,
	input  logic                    rst,
	input  lsq_cmd_e                cmd_enq,
	input  logic [`LSQ_IDX_W-1:0]   enq_idx,
	input  logic [`SEQ_W-1:0]       enq_seq,
	input  lsq_cmd_e                cmd_set,
	input  logic [`ROB_IDX_W-1:0]   set_rob,
	input  logic [`PADR_W-1:0]      set_padr,
	input  lsq_cmd_e                cmd_iss,
	input  logic [`LSQ_IDX_W-1:0]   iss_idx_o,
	input  lsq_cmd_e                cmd_res,
	input  logic [`LSQ_IDX_W-1:0]   res_idx,
	input  logic [`DATA_W-1:0]      res_data,
	input  logic [`ROB_IDX_W-1:0]   enq_rob,
	input  mem_kind_e               enq_kind,
	input  mem_size_e               enq_size,
	input  logic                    inv_valid,
	input  logic [`ROB_IDX_W-1:0]   inv_rob,
	output logic [`LSQ_ENTRIES-1:0] ent_valid,
	output logic [`LSQ_ENTRIES-1:0] ent_addr_ok,
	output logic [`LSQ_ENTRIES-1:0] ent_issued,
	output logic [`SEQ_W-1:0]       ent_seq [`LSQ_ENTRIES],
	output logic [`PADR_W-1:0]      ent_padr [`LSQ_ENTRIES],
	output logic [`ROB_IDX_W-1:0]   ent_rob [`LSQ_ENTRIES],
	output mem_kind_e               ent_kind [`LSQ_ENTRIES],
	output mem_size_e               ent_size [`LSQ_ENTRIES],
	output logic                    done_valid,
	output logic [`ROB_IDX_W-1:0]   done_rob,
	output logic [`DATA_W-1:0]      done_data
);

	lsq_cmd_e cmd_inv;
	logic [`LSQ_ENTRIES-1:0] set_hit;
	logic [`LSQ_ENTRIES-1:0] inv_hit;

	// The invalidate strobe is its own lane
	assign cmd_inv = inv_valid ? CMD_INV : CMD_NONE;

	// Search by reorder-buffer index, only valid entries can match
	always_comb begin
		for (int i = 0; i < `LSQ_ENTRIES; i++) begin
			set_hit[i] = (cmd_set == CMD_SETADR) && ent_valid[i] && (ent_rob[i] == set_rob);
			inv_hit[i] = (cmd_inv == CMD_INV) && ent_valid[i] && (ent_rob[i] == inv_rob);
		end
	end

	// ==================================================================
	// Entry flags
	// ==================================================================

	always_ff @(posedge clk) begin
		if (rst) begin
			ent_valid <= '0;
			ent_addr_ok <= '0;
			ent_issued <= '0;
			done_valid <= 1'b0;
		end else begin
			done_valid <= (cmd_res == CMD_SETRES);
			// Enqueue only targets a free entry, so it never meets an invalidate
			if (cmd_enq == CMD_ENQ) begin
				ent_valid[enq_idx] <= 1'b1;
				ent_addr_ok[enq_idx] <= 1'b0;
				ent_issued[enq_idx] <= 1'b0;
			end
			if (cmd_iss == CMD_ISSUE)
				ent_issued[iss_idx_o] <= 1'b1;
			for (int i = 0; i < `LSQ_ENTRIES; i++) begin
				if (set_hit[i])
					ent_addr_ok[i] <= 1'b1;
				// Invalidate comes last so it wins over anything else that cycle
				if (inv_hit[i]) begin
					ent_valid[i] <= 1'b0;
					ent_addr_ok[i] <= 1'b0;
					ent_issued[i] <= 1'b0;
				end
			end
		end
	end

	// ==================================================================
	// Entry payload and result
	// ==================================================================

	always_ff @(posedge clk) begin
		if (cmd_enq == CMD_ENQ) begin
			ent_seq[enq_idx] <= enq_seq;
			ent_rob[enq_idx] <= enq_rob;
			ent_kind[enq_idx] <= enq_kind;
			ent_size[enq_idx] <= enq_size;
			ent_padr[enq_idx] <= '0;
		end
		for (int i = 0; i < `LSQ_ENTRIES; i++) begin
			if (set_hit[i])
				ent_padr[i] <= set_padr;
		end
		// Result is reported with the entry's reorder-buffer index
		if (cmd_res == CMD_SETRES) begin
			done_rob <= ent_rob[res_idx];
			done_data <= res_data;
		end
	end

endmodule

// File: hdl/lsq_xlate.sv
// ======================================================================
// Load/store queue address translator
// A 16-slot page map and one registered translation per cycle
// ======================================================================
`timescale 1ns/1ps
`include "lsq_defines.svh"

module lsq_xlate (
	input  logic                  clk,
	input  logic                  rst,
	input  logic                  map_wr,
	input  logic [`VPN_W-1:0]     map_vpn,
	input  logic [`PPN_W-1:0]     map_ppn,
	input  logic                  agen_valid,
	input  logic [`ROB_IDX_W-1:0] agen_rob,
	input  logic [`VADR_W-1:0]    agen_vadr,
	output logic                  xl_valid,
	output logic [`ROB_IDX_W-1:0] xl_rob,
	output logic [`PADR_W-1:0]    xl_padr
);

	localparam int MAP_W = 4;

	logic [`PPN_W-1:0] map_q [2**MAP_W];
	logic [`VPN_W-1:0] vpn;

	assign vpn = agen_vadr[`VADR_W-1:`PAGE_BITS];

	// Page map, slot chosen by the low virtual page number bits
	always_ff @(posedge clk) begin
		if (rst) begin
			for (int i = 0; i < 2**MAP_W; i++)
				map_q[i] <= '0;
		end else if (map_wr) begin
			map_q[map_vpn[MAP_W-1:0]] <= map_ppn;
		end
	end

	always_ff @(posedge clk) begin
		if (rst)
			xl_valid <= 1'b0;
		else
			xl_valid <= agen_valid;
	end

	// Physical address is the mapped page followed by the page offset
	always_ff @(posedge clk) begin
		if (agen_valid) begin
			xl_rob <= agen_rob;
			xl_padr <= {map_q[vpn[MAP_W-1:0]], agen_vadr[`PAGE_BITS-1:0]};
		end
	end

endmodule

// File: hdl/lsq_issue.sv
// ======================================================================
// Load/store queue issue picker
// Finds the oldest unissued entry and sends it to memory once its
// address is known, so requests leave in program order
// ======================================================================
`timescale 1ns/1ps
`include "lsq_defines.svh"

module lsq_issue import lsq_pkg::*; (
	input  logic                    clk,
	input  logic                    rst,
	input  logic [`SEQ_W-1:0]       seq_now,
	input  logic [`LSQ_ENTRIES-1:0] ent_valid,
	input  logic [`LSQ_ENTRIES-1:0] ent_addr_ok,
	input  logic [`LSQ_ENTRIES-1:0] ent_issued,
	input  logic [`SEQ_W-1:0]       ent_seq [`LSQ_ENTRIES],
	input  logic [`PADR_W-1:0]      ent_padr [`LSQ_ENTRIES],
	input  logic [`ROB_IDX_W-1:0]   ent_rob [`LSQ_ENTRIES],
	input  mem_kind_e               ent_kind [`LSQ_ENTRIES],
	input  mem_size_e               ent_size [`LSQ_ENTRIES],
	output logic                    iss_valid,
	output logic [`LSQ_IDX_W-1:0]   iss_idx,
	output logic                    mem_req_valid,
	output logic [`LSQ_IDX_W-1:0]   mem_req_idx,
	output logic [`ROB_IDX_W-1:0]   mem_req_rob,
	output mem_kind_e               mem_req_kind,
	output mem_size_e               mem_req_size,
	output logic [`PADR_W-1:0]      mem_req_padr
);

	localparam int IW = `LSQ_IDX_W;

	logic [`SEQ_W-1:0] age;
	logic [`SEQ_W-1:0] best_age;
	logic found;

	// Age is the distance back from the counter, the largest is the oldest
	always_comb begin
		best_age = '0;
		iss_idx = '0;
		found = 1'b0;
		age = '0;
		for (int i = 0; i < `LSQ_ENTRIES; i++) begin
			age = seq_now - ent_seq[i];
			if (ent_valid[i] && !ent_issued[i] && (!found || age > best_age)) begin
				best_age = age;
				iss_idx = IW'(i);
				found = 1'b1;
			end
		end
	end

	// A younger addressed entry waits behind an unaddressed older one
	assign iss_valid = found && ent_addr_ok[iss_idx];

	always_ff @(posedge clk) begin
		if (rst)
			mem_req_valid <= 1'b0;
		else
			mem_req_valid <= iss_valid;
	end

	always_ff @(posedge clk) begin
		if (iss_valid) begin
			mem_req_idx <= iss_idx;
			mem_req_rob <= ent_rob[iss_idx];
			mem_req_kind <= ent_kind[iss_idx];
			mem_req_size <= ent_size[iss_idx];
			mem_req_padr <= ent_padr[iss_idx];
		end
	end

endmodule

// File: hdl/lsq_top.sv
// ======================================================================
// Load/store queue
// Control, entry array, translator and issue picker wired together
// ======================================================================
`timescale 1ns/1ps
`include "lsq_defines.svh"

module lsq_top import lsq_pkg::*; (
	input  logic                  clk,
	input  logic                  rst,
	input  logic                  enq_valid,
	input  logic [`ROB_IDX_W-1:0] enq_rob,
	input  mem_kind_e             enq_kind,
	input  mem_size_e             enq_size,
	input  logic                  agen_valid,
	input  logic [`ROB_IDX_W-1:0] agen_rob,
	input  logic [`VADR_W-1:0]    agen_vadr,
	input  logic                  inv_valid,
	input  logic [`ROB_IDX_W-1:0] inv_rob,
	input  logic                  map_wr,
	input  logic [`VPN_W-1:0]     map_vpn,
	input  logic [`PPN_W-1:0]     map_ppn,
	input  logic                  mem_resp_valid,
	input  logic [`LSQ_IDX_W-1:0] mem_resp_idx,
	input  logic [`DATA_W-1:0]    mem_resp_data,
	output logic                  mem_req_valid,
	output logic [`LSQ_IDX_W-1:0] mem_req_idx,
	output logic [`ROB_IDX_W-1:0] mem_req_rob,
	output mem_kind_e             mem_req_kind,
	output mem_size_e             mem_req_size,
	output logic [`PADR_W-1:0]    mem_req_padr,
	output logic                  done_valid,
	output logic [`ROB_IDX_W-1:0] done_rob,
	output logic [`DATA_W-1:0]    done_data,
	output logic                  lsq_full,
	output logic [`LSQ_IDX_W:0]   lsq_count
);

	// Command lanes
	lsq_cmd_e cmd_enq, cmd_set, cmd_iss, cmd_res;
	logic [`LSQ_IDX_W-1:0] enq_idx, iss_idx_o, res_idx;
	logic [`SEQ_W-1:0] enq_seq, seq_now;
	logic [`ROB_IDX_W-1:0] set_rob;
	logic [`PADR_W-1:0] set_padr;
	logic [`DATA_W-1:0] res_data;

	// Translator and picker strobes
	logic xl_valid, iss_valid;
	logic [`ROB_IDX_W-1:0] xl_rob;
	logic [`PADR_W-1:0] xl_padr;
	logic [`LSQ_IDX_W-1:0] iss_idx;

	// Per-entry state
	logic [`LSQ_ENTRIES-1:0] ent_valid, ent_addr_ok, ent_issued;
	logic [`SEQ_W-1:0] ent_seq [`LSQ_ENTRIES];
	logic [`PADR_W-1:0] ent_padr [`LSQ_ENTRIES];
	logic [`ROB_IDX_W-1:0] ent_rob [`LSQ_ENTRIES];
	mem_kind_e ent_kind [`LSQ_ENTRIES];
	mem_size_e ent_size [`LSQ_ENTRIES];

	lsq_ctrl ctrl0 (.*);
	lsq_entries entries0 (.*);
	lsq_xlate xlate0 (.*);
	lsq_issue issue0 (.*);

endmodule

// File: bench/lsq_tb.sv
// ======================================================================
// Load/store queue testbench
// Drives lsq_top through translation, ordering, results, full queue
// and invalidate, checking against a program-order model
// ======================================================================
`timescale 1ns/1ps
`include "lsq_defines.svh"

module lsq_tb import lsq_pkg::*; ();

	localparam int TIMEOUT = 50;

	logic clk;
	logic rst;
	logic enq_valid;
	logic [`ROB_IDX_W-1:0] enq_rob;
	mem_kind_e enq_kind;
	mem_size_e enq_size;
	logic agen_valid;
	logic [`ROB_IDX_W-1:0] agen_rob;
	logic [`VADR_W-1:0] agen_vadr;
	logic inv_valid;
	logic [`ROB_IDX_W-1:0] inv_rob;
	logic map_wr;
	logic [`VPN_W-1:0] map_vpn;
	logic [`PPN_W-1:0] map_ppn;
	logic mem_resp_valid;
	logic [`LSQ_IDX_W-1:0] mem_resp_idx;
	logic [`DATA_W-1:0] mem_resp_data;
	logic mem_req_valid;
	logic [`LSQ_IDX_W-1:0] mem_req_idx;
	logic [`ROB_IDX_W-1:0] mem_req_rob;
	mem_kind_e mem_req_kind;
	mem_size_e mem_req_size;
	logic [`PADR_W-1:0] mem_req_padr;
	logic done_valid;
	logic [`ROB_IDX_W-1:0] done_rob;
	logic [`DATA_W-1:0] done_data;
	logic lsq_full;
	logic [`LSQ_IDX_W:0] lsq_count;

	// Reference model
	// Live entries, operations still waiting to issue, issued ones awaiting a result
	logic [31:0] lcg_state;
	logic [`PPN_W-1:0] map_copy [16];
	logic [`VADR_W-1:0] vadr_of_rob [32];
	logic [`ROB_IDX_W-1:0] live_rob [$];
	logic [`ROB_IDX_W-1:0] pend_rob [$];
	mem_kind_e pend_kind [$];
	mem_size_e pend_size [$];
	logic [`LSQ_IDX_W-1:0] got_idx [$];
	logic [`ROB_IDX_W-1:0] got_rob [$];

	// Entry slots the queue should have handed out, and who holds them
	logic [`LSQ_ENTRIES-1:0] slot_busy;
	logic [`ROB_IDX_W-1:0] slot_rob [`LSQ_ENTRIES];

	lsq_top dut0 (.*);

	initial begin
		clk = 1'b0;
		forever #10 clk = ~clk;
	end

	// ==================================================================
	// Helpers
	// ==================================================================

	function automatic logic [31:0] lcg_next();
		lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
		return lcg_state;
	endfunction

	// Mapped page number of the slot picked by the low four VPN bits followed by the offset
	function automatic logic [`PADR_W-1:0] expect_padr(input logic [`VADR_W-1:0] vadr);
		return {map_copy[vadr[`PAGE_BITS+3:`PAGE_BITS]], vadr[`PAGE_BITS-1:0]};
	endfunction

	// Entries are taken lowest index first
	function automatic int lowest_free_slot();
		for (int i = 0; i < `LSQ_ENTRIES; i++)
			if (!slot_busy[i])
				return i;
		return -1;
	endfunction

	function automatic int slot_holding(input logic [`ROB_IDX_W-1:0] rob);
		for (int i = 0; i < `LSQ_ENTRIES; i++)
			if (slot_busy[i] && slot_rob[i] == rob)
				return i;
		return -1;
	endfunction

	task automatic abort_run(input string why);
		$display("%s", why);
		$display("Simulation FAILED");
		$fatal(1, "run stopped");
	endtask

	task automatic check_hex(input string name, input logic [31:0] got,
			input logic [31:0] exp);
		assert (got == exp) else
			abort_run($sformatf("CHECK FAILED %s got 0x%h expected 0x%h", name, got, exp));
	endtask

	task automatic do_map(input logic [3:0] slot);
		logic [31:0] r;
		r = lcg_next();
		map_copy[slot] = r[`PPN_W+7:8];
		@(posedge clk);
		map_wr <= 1'b1;
		// The map only looks at the low four VPN bits so the upper ones are noise
		map_vpn <= {r[29:24], slot};
		map_ppn <= r[`PPN_W+7:8];
		@(posedge clk);
		map_wr <= 1'b0;
	endtask

	task automatic do_enq(input logic [`ROB_IDX_W-1:0] rob);
		logic [31:0] r;
		mem_kind_e kind;
		mem_size_e size;
		int slot;
		r = lcg_next();
		kind = mem_kind_e'(r[20]);
		size = mem_size_e'(2'(r[27:20] % 3));
		@(posedge clk);
		enq_valid <= 1'b1;
		enq_rob <= rob;
		enq_kind <= kind;
		enq_size <= size;
		@(posedge clk);
		enq_valid <= 1'b0;
		// A full queue drops the enqueue
		if (live_rob.size() < `LSQ_ENTRIES) begin
			live_rob.push_back(rob);
			pend_rob.push_back(rob);
			pend_kind.push_back(kind);
			pend_size.push_back(size);
			slot = lowest_free_slot();
			slot_busy[slot] = 1'b1;
			slot_rob[slot] = rob;
		end
		@(negedge clk);
		check_hex("lsq_count", 32'(lsq_count), live_rob.size());
		check_hex("lsq_full", 32'(lsq_full), 32'(live_rob.size() == `LSQ_ENTRIES));
	endtask

	task automatic do_agen(input logic [`ROB_IDX_W-1:0] rob);
		logic [31:0] r;
		r = lcg_next();
		vadr_of_rob[rob] = r[27:12];
		@(posedge clk);
		agen_valid <= 1'b1;
		agen_rob <= rob;
		agen_vadr <= r[27:12];
		@(posedge clk);
		agen_valid <= 1'b0;
	endtask

	task automatic do_inv(input logic [`ROB_IDX_W-1:0] rob);
		@(posedge clk);
		inv_valid <= 1'b1;
		inv_rob <= rob;
		@(posedge clk);
		inv_valid <= 1'b0;
		for (int i = live_rob.size() - 1; i >= 0; i--)
			if (live_rob[i] == rob)
				live_rob.delete(i);
		for (int i = pend_rob.size() - 1; i >= 0; i--) begin
			if (pend_rob[i] == rob) begin
				pend_rob.delete(i);
				pend_kind.delete(i);
				pend_size.delete(i);
			end
		end
		for (int i = 0; i < `LSQ_ENTRIES; i++)
			if (slot_busy[i] && slot_rob[i] == rob)
				slot_busy[i] = 1'b0;
		@(negedge clk);
		check_hex("lsq_count", 32'(lsq_count), live_rob.size());
	endtask

	// Oldest pending operation must be the one on the request port
	task automatic check_req_fields();
		logic [`ROB_IDX_W-1:0] rob;
		assert (pend_rob.size() > 0) else
			abort_run("A memory request appeared with no operation pending");
		rob = pend_rob.pop_front();
		check_hex("mem_req_rob", 32'(mem_req_rob), 32'(rob));
		check_hex("mem_req_idx", 32'(mem_req_idx), 32'(slot_holding(rob)));
		check_hex("mem_req_kind", 32'(mem_req_kind), 32'(pend_kind.pop_front()));
		check_hex("mem_req_size", 32'(mem_req_size), 32'(pend_size.pop_front()));
		check_hex("mem_req_padr", 32'(mem_req_padr), 32'(expect_padr(vadr_of_rob[rob])));
		got_idx.push_back(mem_req_idx);
		got_rob.push_back(rob);
	endtask

	task automatic expect_req();
		int n;
		n = 0;
		@(negedge clk);
		while (!mem_req_valid && n < TIMEOUT) begin
			@(negedge clk);
			n++;
		end
		assert (mem_req_valid) else
			abort_run("Timed out waiting for a memory request");
		check_req_fields();
	endtask

	// Each issued request gets one response and is reported in the following cycle
	task automatic check_results();
		logic [31:0] data;
		logic [`LSQ_IDX_W-1:0] idx;
		logic [`ROB_IDX_W-1:0] rob;
		while (got_idx.size() > 0) begin
			idx = got_idx.pop_front();
			rob = got_rob.pop_front();
			data = lcg_next();
			@(posedge clk);
			mem_resp_valid <= 1'b1;
			mem_resp_idx <= idx;
			mem_resp_data <= data;
			@(posedge clk);
			mem_resp_valid <= 1'b0;
			@(negedge clk);
			check_hex("done_valid", 32'(done_valid), 32'd1);
			check_hex("done_rob", 32'(done_rob), 32'(rob));
			check_hex("done_data", done_data, data);
		end
	endtask

	// ==================================================================
	// Stimulus
	// ==================================================================

	initial begin
		lcg_state = 32'd33;
		slot_busy = '0;
		rst <= 1'b1;
		enq_valid <= 1'b0;
		enq_rob <= '0;
		enq_kind <= MK_LOAD;
		enq_size <= MS_BYTE;
		agen_valid <= 1'b0;
		agen_rob <= '0;
		agen_vadr <= '0;
		inv_valid <= 1'b0;
		inv_rob <= '0;
		map_wr <= 1'b0;
		map_vpn <= '0;
		map_ppn <= '0;
		mem_resp_valid <= 1'b0;
		mem_resp_idx <= '0;
		mem_resp_data <= '0;
		repeat (8) @(posedge clk);
		rst <= 1'b0;

		@(negedge clk);
		check_hex("mem_req_valid", 32'(mem_req_valid), 32'd0);
		check_hex("done_valid", 32'(done_valid), 32'd0);
		check_hex("lsq_full", 32'(lsq_full), 32'd0);
		check_hex("lsq_count", 32'(lsq_count), 32'd0);

		for (int s = 0; s < 16; s++)
			do_map(4'(s));

		// A single operation requests memory exactly three cycles after its agen strobe
		do_enq(5'd1);
		do_agen(5'd1);
		for (int c = 1; c <= 3; c++) begin
			@(negedge clk);
			check_hex("mem_req_valid", 32'(mem_req_valid), 32'(c == 3));
		end
		check_req_fields();
		check_results();
		do_inv(5'd1);

		// Addresses arrive youngest first but requests still leave oldest first
		for (int k = 0; k < 4; k++)
			do_enq(5'(2 + k));
		for (int k = 3; k >= 0; k--)
			do_agen(5'(2 + k));
		for (int k = 0; k < 4; k++)
			expect_req();
		check_results();
		for (int k = 0; k < 4; k++)
			do_inv(5'(2 + k));

		// Fill the queue and send one more that must be dropped
		for (int k = 0; k < 8; k++)
			do_enq(5'(8 + k));
		do_enq(5'd20);
		check_hex("lsq_count", 32'(lsq_count), 32'd8);
		for (int k = 0; k < 8; k++)
			do_inv(5'(8 + k));

		// Cancel the oldest before its address so the younger two go in order
		do_enq(5'd21);
		do_enq(5'd22);
		do_enq(5'd23);
		do_inv(5'd21);
		do_agen(5'd21);
		for (int c = 0; c < 8; c++) begin
			@(negedge clk);
			check_hex("mem_req_valid", 32'(mem_req_valid), 32'd0);
		end
		do_agen(5'd23);
		do_agen(5'd22);
		expect_req();
		expect_req();
		check_results();

		$display("Simulation PASSED");
		$finish;
	end

endmodule

// File: project.f
+incdir+hdl
hdl/lsq_pkg.sv
hdl/lsq_ctrl.sv
hdl/lsq_entries.sv
hdl/lsq_xlate.sv
hdl/lsq_issue.sv
hdl/lsq_top.sv
bench/lsq_tb.sv

// File: run_sim.sh
#!/bin/sh
# Build and run the load/store queue testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal \
	-f project.f --top-module lsq_tb -o lsq_sim

./obj_dir/lsq_sim
